// File: hdl/wb_pkg.sv
package wb_pkg;

    localparam int slots      = 2;
    localparam int data_w     = 32;
    localparam int addr_w     = 32;
    localparam int reg_n      = 8;                         // segment file is the same size
    localparam int seg_w      = 16;
    localparam int sq_depth   = 4;
    localparam int line_bytes = 16;

    localparam int reg_aw    = $clog2(reg_n);
    localparam int line_lsb  = $clog2(line_bytes);         // low bits cleared in a fetch line
    localparam int sq_ptr_w  = $clog2(sq_depth);
    localparam int sq_cnt_w  = $clog2(sq_depth + 1);

    typedef enum logic [1:0] {
        kind_none,
        kind_reg,
        kind_seg,
        kind_mem
    } slot_kind_e;

    typedef enum logic [1:0] {
        op_plain,
        op_branch,
        op_far_jump                                        // loads eip and cs together
    } wb_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_commit,
        st_hold
    } wb_state_e;

    typedef struct packed {
        slot_kind_e          kind;
        logic                wb;
        logic [addr_w-1:0]   dest;                         // reg number or memory address
        logic [data_w-1:0]   data;
    } wb_slot_t;

    typedef struct packed {
        wb_slot_t [slots-1:0] slot;
        wb_op_e               op;
        logic [addr_w-1:0]    eip;
        logic                 br_taken;
        logic                 br_correct;
        logic [addr_w-1:0]    br_target;
        logic                 ie;
        logic [2:0]           ie_type;
    } wb_bundle_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } store_t;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] new_eip;
        logic [addr_w-1:0] fip_even;
        logic [addr_w-1:0] fip_odd;
        logic [seg_w-1:0]  cs;
    } resteer_t;

endpackage

// File: hdl/wb_control.sv
`timescale 1ns/1ps

module wb_control (
    input  logic                                clk,
    input  logic                                rst,
    input  wb_pkg::wb_bundle_t                  in_bundle,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic                                sq_full,
    output logic                                commit_valid,
    output wb_pkg::wb_bundle_t                  held,
    output logic [wb_pkg::slots-1:0]            push_valid,
    output wb_pkg::store_t [wb_pkg::slots-1:0]  push_data
);
    import wb_pkg::*;

    wb_state_e state;
    wb_state_e state_nxt;
    logic      live;                                       // set once out of reset
    logic      has_store;
    logic      stall;
    logic      accept;

    always_comb begin
        has_store = 1'b0;
        for (int i = 0; i < slots; i++) begin
            has_store |= held.slot[i].wb && (held.slot[i].kind == kind_mem);
        end
    end

    assign stall = (state != st_idle) && has_store && sq_full;

    always_comb begin
        unique case (state)
            st_commit: commit_valid = !stall;
            st_hold:   commit_valid = !sq_full;            // held store waits for queue room
            default:   commit_valid = 1'b0;
        endcase
    end

    assign in_ready = live && ((state == st_idle) || commit_valid);
    assign accept   = in_valid && in_ready;

    always_comb begin
        state_nxt = state;
        if (accept) begin
            state_nxt = st_commit;
        end else if (stall) begin
            state_nxt = st_hold;
        end else if (commit_valid) begin
            state_nxt = st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            live  <= 1'b0;
        end else begin
            state <= state_nxt;
            live  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= in_bundle;                             // commit register
        end
    end

    always_comb begin
        for (int i = 0; i < slots; i++) begin
            push_valid[i]     = commit_valid && held.slot[i].wb &&
                                (held.slot[i].kind == kind_mem);
            push_data[i].addr = held.slot[i].dest;
            push_data[i].data = held.slot[i].data;
        end
    end

endmodule

// File: hdl/reg_commit.sv
`timescale 1ns/1ps

module reg_commit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 commit_valid,
    input  wb_pkg::wb_slot_t [wb_pkg::slots-1:0] slots,
    input  logic [wb_pkg::reg_aw-1:0]            rd_addr,
    output logic [wb_pkg::data_w-1:0]            rd_data,
    input  logic [wb_pkg::reg_aw-1:0]            seg_rd_addr,
    output logic [wb_pkg::seg_w-1:0]             seg_rd_data
);
    import wb_pkg::*;

    logic [data_w-1:0]        gpr [reg_n];
    logic [seg_w-1:0]         seg [reg_n];
    logic [wb_pkg::slots-1:0] gpr_we;
    logic [wb_pkg::slots-1:0] seg_we;
    logic [reg_aw-1:0]        waddr [wb_pkg::slots];

    always_comb begin
        for (int i = 0; i < wb_pkg::slots; i++) begin
            gpr_we[i] = commit_valid && slots[i].wb && (slots[i].kind == kind_reg);
            seg_we[i] = commit_valid && slots[i].wb && (slots[i].kind == kind_seg);
            waddr[i]  = slots[i].dest[reg_aw-1:0];
        end
    end

    // later slots overwrite earlier ones on the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < reg_n; r++) begin
                gpr[r] <= '0;
                seg[r] <= '0;
            end
        end else begin
            for (int i = 0; i < wb_pkg::slots; i++) begin
                if (gpr_we[i]) begin
                    gpr[waddr[i]] <= slots[i].data;
                end
                if (seg_we[i]) begin
                    seg[waddr[i]] <= slots[i].data[seg_w-1:0];   // selector in low half
                end
            end
        end
    end

    assign rd_data     = gpr[rd_addr];
    assign seg_rd_data = seg[seg_rd_addr];

endmodule

// File: hdl/store_queue.sv
`timescale 1ns/1ps

module store_queue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [wb_pkg::slots-1:0]            push_valid,
    input  wb_pkg::store_t [wb_pkg::slots-1:0]  push_data,
    output logic                                full,
    output wb_pkg::store_t                      mem_out,
    output logic                                mem_valid,
    input  logic                                mem_ready
);
    import wb_pkg::*;

    store_t              mem [sq_depth];
    logic [sq_ptr_w-1:0] wr_ptr;
    logic [sq_ptr_w-1:0] rd_ptr;
    logic [sq_cnt_w-1:0] count;
    logic [sq_cnt_w-1:0] n_push;
    logic [sq_cnt_w-1:0] free_n;
    logic [sq_ptr_w-1:0] wr_idx [slots];
    logic                pop;

    // pack the pushes in slot order behind wr_ptr
    always_comb begin
        logic [sq_ptr_w-1:0] ofs;
        ofs    = '0;
        n_push = '0;
        for (int i = 0; i < slots; i++) begin
            wr_idx[i] = wr_ptr + ofs;
            ofs       = ofs + sq_ptr_w'(push_valid[i]);
            n_push    = n_push + sq_cnt_w'(push_valid[i]);
        end
    end

    assign mem_valid = (count != '0);
    assign mem_out   = mem[rd_ptr];
    assign pop       = mem_valid && mem_ready;
    assign free_n    = sq_cnt_w'(sq_depth) - count + sq_cnt_w'(pop);
    assign full      = free_n < sq_cnt_w'(slots);         // room for a two-store bundle

    always_ff @(posedge clk) begin
        for (int i = 0; i < slots; i++) begin
            if (push_valid[i]) begin
                mem[wr_idx[i]] <= push_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + sq_ptr_w'(n_push);
            rd_ptr <= rd_ptr + sq_ptr_w'(pop);
            count  <= count + n_push - sq_cnt_w'(pop);
        end
    end

endmodule

// File: hdl/resteer_unit.sv
`timescale 1ns/1ps

module resteer_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               commit_valid,
    input  wb_pkg::wb_bundle_t held,
    input  logic               interrupt_in,
    output wb_pkg::resteer_t   resteer,
    output logic               ie_valid,
    output logic [3:0]         ie_code
);
    import wb_pkg::*;

    logic [seg_w-1:0]  cur_cs;
    logic [seg_w-1:0]  far_cs;
    logic [addr_w-1:0] target;
    logic [addr_w-1:0] line_cur;
    logic [addr_w-1:0] line_nxt;
    logic              far;

    assign far      = (held.op == op_far_jump);
    assign far_cs   = held.slot[1].data[data_w-1 -: seg_w];        // cs in upper half
    assign target   = far ? held.slot[0].data : held.br_target;
    assign line_cur = {target[addr_w-1:line_lsb], {line_lsb{1'b0}}};
    assign line_nxt = line_cur + addr_w'(line_bytes);

    always_comb begin
        resteer.valid    = commit_valid && (!held.br_correct || far);
        resteer.new_eip  = (held.br_taken || far) ? target : held.eip;
        resteer.fip_even = target[line_lsb] ? line_nxt : line_cur;
        resteer.fip_odd  = target[line_lsb] ? line_cur : line_nxt;
        resteer.cs       = far ? far_cs : cur_cs;
    end

    assign ie_valid = commit_valid && (held.ie || interrupt_in);
    assign ie_code  = {interrupt_in, held.ie_type};

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_cs <= '0;
        end else if (commit_valid && far) begin
            cur_cs <= far_cs;
        end
    end

endmodule

// File: hdl/writeback_top.sv
`timescale 1ns/1ps

module writeback_top (
    input  logic                      clk,
    input  logic                      rst,
    input  wb_pkg::wb_bundle_t        in_bundle,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic                      interrupt_in,
    input  logic [wb_pkg::reg_aw-1:0] rd_addr,
    output logic [wb_pkg::data_w-1:0] rd_data,
    input  logic [wb_pkg::reg_aw-1:0] seg_rd_addr,
    output logic [wb_pkg::seg_w-1:0]  seg_rd_data,
    output wb_pkg::store_t            mem_out,
    output logic                      mem_valid,
    input  logic                      mem_ready,
    output wb_pkg::resteer_t          resteer,
    output logic                      ie_valid,
    output logic [3:0]                ie_code
);
    import wb_pkg::*;

    wb_bundle_t              held;
    logic                    commit_valid;
    logic                    sq_full;
    logic [slots-1:0]        push_valid;
    store_t [slots-1:0]      push_data;

    wb_control u_control (
        .clk, .rst, .in_bundle, .in_valid, .in_ready, .sq_full,
        .commit_valid, .held, .push_valid, .push_data
    );

    reg_commit u_reg_commit (
        .clk, .rst, .commit_valid,
        .slots       (held.slot),
        .rd_addr, .rd_data, .seg_rd_addr, .seg_rd_data
    );

    store_queue u_store_queue (
        .clk, .rst, .push_valid, .push_data,
        .full        (sq_full),
        .mem_out, .mem_valid, .mem_ready
    );

    resteer_unit u_resteer (
        .clk, .rst, .commit_valid, .held, .interrupt_in,
        .resteer, .ie_valid, .ie_code
    );

endmodule

// File: sim/writeback_properties.sv
`timescale 1ns/1ps

module writeback_properties (
    input logic                        clk,
    input logic                        rst,
    input logic                        in_valid,
    input logic                        in_ready,
    input wb_pkg::wb_bundle_t          in_bundle,
    input wb_pkg::wb_bundle_t          held,
    input logic                        sq_full,
    input logic                        commit_valid,
    input logic                        mem_valid,
    input logic                        mem_ready,
    input wb_pkg::store_t              mem_out,
    input logic [wb_pkg::sq_cnt_w-1:0] count
);
    import wb_pkg::*;

    logic held_store;

    always_comb begin
        held_store = 1'b0;
        for (int i = 0; i < slots; i++) begin
            held_store |= held.slot[i].wb && (held.slot[i].kind == kind_mem);
        end
    end

    a_bundle_stable: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> $stable(in_bundle))
        else $error("in_bundle changed while waiting for in_ready");

    a_no_commit_in_stall: assert property (@(posedge clk) disable iff (rst)
        held_store && sq_full |-> !commit_valid)
        else $error("store bundle retired with the queue full");

    a_mem_valid_held: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_out))
        else $error("mem_valid dropped or mem_out changed before mem_ready");

    a_occupancy: assert property (@(posedge clk) disable iff (rst)
        count <= sq_cnt_w'(sq_depth))
        else $error("store queue occupancy above its depth");

endmodule

// control side, queue signals tied off
bind wb_control writeback_properties u_control_props (
    .clk, .rst, .in_valid, .in_ready, .in_bundle, .held, .sq_full, .commit_valid,
    .mem_valid (1'b0), .mem_ready (1'b1), .mem_out ('0), .count ('0)
);

bind store_queue writeback_properties u_queue_props (
    .clk, .rst, .mem_valid, .mem_ready, .mem_out, .count,
    .in_valid (1'b0), .in_ready (1'b1), .in_bundle ('0), .held ('0),
    .sq_full (full), .commit_valid (1'b0)
);

// File: sim/tb_writeback.sv
`timescale 1ns/1ps

module tb_writeback;
    import wb_pkg::*;

    localparam int period    = 100;
    localparam int n_bundles = 32;                         // watchdog budget

    logic              clk;
    logic              rst;
    wb_bundle_t        in_bundle;
    logic              in_valid;
    logic              in_ready;
    logic              interrupt_in;
    logic [reg_aw-1:0] rd_addr;
    logic [data_w-1:0] rd_data;
    logic [reg_aw-1:0] seg_rd_addr;
    logic [seg_w-1:0]  seg_rd_data;
    store_t            mem_out;
    logic              mem_valid;
    logic              mem_ready;
    resteer_t          resteer;
    logic              ie_valid;
    logic [3:0]        ie_code;

    integer            seed = 32'h1c66;
    int                errors = 0;
    int                test_err0 = 0;
    int                n_tests = 0;
    int                n_failed = 0;
    logic              started = 1'b0;
    logic              stall_seen = 1'b0;
    logic [data_w-1:0] gpr_m [reg_n];
    logic [seg_w-1:0]  seg_m [reg_n];
    logic [seg_w-1:0]  cs_m;
    wb_bundle_t        pend [$];                           // accepted, not yet retired
    store_t            exp_stores [$];

    writeback_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    function automatic wb_slot_t make_slot(slot_kind_e kind);
        wb_slot_t s;
        s.kind = kind;
        s.wb   = 1'b1;
        s.dest = (kind == kind_mem) ? $random(seed) : 32'(3'($random(seed)));
        s.data = $random(seed);
        return s;
    endfunction

    function automatic wb_bundle_t base_bundle();
        wb_bundle_t b;
        b            = '0;
        b.op         = op_plain;
        b.eip        = $random(seed);
        b.br_correct = 1'b1;
        b.br_target  = $random(seed);
        return b;
    endfunction

    function automatic resteer_t exp_resteer(wb_bundle_t b, logic [seg_w-1:0] cs);
        resteer_t          r;
        logic              far;
        logic [addr_w-1:0] tgt;
        logic [addr_w-1:0] lo_line;
        far        = (b.op == op_far_jump);
        tgt        = far ? b.slot[0].data : b.br_target;
        lo_line    = {tgt[addr_w-1:4], 4'b0000};
        r.valid    = !b.br_correct || far;
        r.new_eip  = (b.br_taken || far) ? tgt : b.eip;
        r.fip_even = tgt[4] ? lo_line + 32'd16 : lo_line;  // bit 4 set means odd line
        r.fip_odd  = tgt[4] ? lo_line : lo_line + 32'd16;
        r.cs       = far ? b.slot[1].data[31:16] : cs;
        return r;
    endfunction

    function automatic void apply_commit(wb_bundle_t b);
        store_t st;
        for (int i = 0; i < slots; i++) begin
            st.addr = b.slot[i].dest;
            st.data = b.slot[i].data;
            if (b.slot[i].wb && b.slot[i].kind == kind_reg) begin
                gpr_m[b.slot[i].dest[reg_aw-1:0]] = b.slot[i].data;
            end else if (b.slot[i].wb && b.slot[i].kind == kind_seg) begin
                seg_m[b.slot[i].dest[reg_aw-1:0]] = b.slot[i].data[seg_w-1:0];
            end else if (b.slot[i].wb && b.slot[i].kind == kind_mem) begin
                exp_stores.push_back(st);
            end
        end
        if (b.op == op_far_jump) begin
            cs_m = b.slot[1].data[31:16];
        end
    endfunction

    task automatic note_mismatch(string what);
        $display("Fail %0t: %s", $time, what);
        errors++;
    endtask

    task automatic close_test(string name);
        n_tests++;
        if (errors != test_err0) begin
            n_failed++;
        end
        $display("%-16s %s", name, (errors == test_err0) ? "ok" : "FAILED");
        test_err0 = errors;
    endtask

    task automatic send(wb_bundle_t b);
        in_bundle = b;
        in_valid  = 1'b1;
        do @(negedge clk); while (!in_ready);
        pend.push_back(b);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (pend.size() != 0 || exp_stores.size() != 0);
        #1;
    endtask

    task automatic check_regs();
        for (int r = 0; r < reg_n; r++) begin
            rd_addr     = reg_aw'(r);
            seg_rd_addr = reg_aw'(r);
            @(negedge clk);
            assert (rd_data == gpr_m[r])
                else note_mismatch($sformatf("gpr %0d reads %h, want %h", r, rd_data, gpr_m[r]));
            assert (seg_rd_data == seg_m[r])
                else note_mismatch($sformatf("seg %0d reads %h, want %h", r, seg_rd_data, seg_m[r]));
            @(posedge clk);
            #1;
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        wb_bundle_t cb;
        store_t     st;
        if (!rst) begin
            if (mem_valid && mem_ready) begin
                if (exp_stores.size() == 0) begin
                    note_mismatch("a store left the queue with none expected");
                end else begin
                    st = exp_stores.pop_front();
                    assert (mem_out == st)
                        else note_mismatch($sformatf("store %h, want %h", mem_out, st));
                end
            end
            if (started && !in_ready) begin
                stall_seen = 1'b1;
                assert (pend.size() != 0 && (pend[0].slot[0].kind == kind_mem ||
                                             pend[0].slot[1].kind == kind_mem))
                    else note_mismatch("in_ready low without a held store");
            end
            if (u_dut.commit_valid) begin
                if (pend.size() == 0) begin
                    note_mismatch("commit with no bundle outstanding");
                end else begin
                    cb = pend.pop_front();
                    assert (resteer == exp_resteer(cb, cs_m))
                        else note_mismatch($sformatf("resteer %h", resteer));
                    assert (ie_valid == (cb.ie || interrupt_in) &&
                            ie_code == {interrupt_in, cb.ie_type})
                        else note_mismatch($sformatf("ie_valid %b ie_code %h", ie_valid, ie_code));
                    apply_commit(cb);
                end
            end else begin
                assert (!resteer.valid && !ie_valid)
                    else note_mismatch("resteer or exception raised outside a retire");
            end
        end
    end

    initial begin
        wb_bundle_t b;
        in_bundle    = '0;
        in_valid     = 1'b0;
        interrupt_in = 1'b0;
        rd_addr      = '0;
        seg_rd_addr  = '0;
        mem_ready    = 1'b1;
        cs_m         = '0;
        for (int r = 0; r < reg_n; r++) begin
            gpr_m[r] = '0;
            seg_m[r] = '0;
        end
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        assert (!in_ready && !u_dut.commit_valid && !mem_valid && !resteer.valid && !ie_valid)
            else note_mismatch("outputs active right after reset");
        @(posedge clk);
        #1;
        started = 1'b1;
        check_regs();
        close_test("reset state");

        for (int n = 0; n < 12; n++) begin
            b         = base_bundle();
            b.slot[0] = make_slot(1'($random(seed)) ? kind_reg : kind_seg);
            b.slot[1] = make_slot(1'($random(seed)) ? kind_reg : kind_seg);
            if (n % 3 == 0) begin
                b.slot[1].kind = b.slot[0].kind;           // same register, slot 1 wins
                b.slot[1].dest = b.slot[0].dest;
            end
            send(b);
        end
        wait_idle();
        check_regs();
        close_test("register commit");

        for (int n = 0; n < 8; n++) begin
            b         = base_bundle();
            b.slot[0] = make_slot(kind_mem);
            b.slot[1] = make_slot(1'($random(seed)) ? kind_mem : kind_reg);
            send(b);
        end
        wait_idle();
        close_test("store order");

        // two full store bundles, a register bundle, then a stalled store
        mem_ready  = 1'b0;
        stall_seen = 1'b0;
        for (int n = 0; n < 4; n++) begin
            b         = base_bundle();
            b.slot[0] = make_slot(n == 2 ? kind_reg : kind_mem);
            b.slot[1] = make_slot(n >= 2 ? kind_seg : kind_mem);
            send(b);
        end
        repeat (4) @(posedge clk);
        #1;
        mem_ready = 1'b1;
        b         = base_bundle();
        b.slot[0] = make_slot(kind_reg);
        send(b);
        wait_idle();
        check_regs();
        assert (stall_seen) else begin
            $display("in_ready never dropped while the store queue was full");
            errors++;
        end
        close_test("back-pressure");

        b              = base_bundle();
        b.op           = op_branch;
        b.br_taken     = 1'b1;
        b.br_correct   = 1'b0;
        b.br_target[4] = 1'b1;
        send(b);
        b                 = base_bundle();
        b.op              = op_far_jump;
        b.slot[0].data    = $random(seed);
        b.slot[0].data[4] = 1'b0;
        b.slot[1].data    = $random(seed);
        send(b);
        b          = base_bundle();
        b.op       = op_branch;
        b.br_taken = 1'b1;
        send(b);
        wait_idle();
        close_test("resteer");

        b         = base_bundle();
        b.ie      = 1'b1;
        b.ie_type = 3'($random(seed));
        send(b);
        wait_idle();
        interrupt_in = 1'b1;
        b            = base_bundle();
        b.ie_type    = 3'($random(seed));
        send(b);
        wait_idle();
        interrupt_in = 1'b0;
        close_test("exceptions");

        $display("%0d tests, %0d failed, %0d check errors", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #((n_bundles * 40 + 10) * period);
        $display("Timeout: the run did not finish in the time allowed for %0d bundles", n_bundles);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog.f
hdl/wb_pkg.sv
hdl/wb_control.sv
hdl/reg_commit.sv
hdl/store_queue.sv
hdl/resteer_unit.sv
hdl/writeback_top.sv
sim/writeback_properties.sv
sim/tb_writeback.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_writeback
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
